/* logic/cpu_defs.svh */
// widths, memory depths and instruction encodings for the core
// memory address widths must match the depths below
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

`define CPU_WORD_W      32
`define CPU_REG_AW      5

`define CPU_IMEM_DEPTH  64
`define CPU_IMEM_AW     6
`define CPU_DMEM_DEPTH  16
`define CPU_DMEM_AW     4

`define CPU_OP_RTYPE    6'h00
`define CPU_OP_ADDI     6'h08
`define CPU_OP_LW       6'h23
`define CPU_OP_SW       6'h2B

`define CPU_FN_ADD      6'h20
`define CPU_FN_SUB      6'h22
`define CPU_FN_AND      6'h24
`define CPU_FN_OR       6'h25
`define CPU_FN_SLT      6'h2A

`endif

/* logic/cpu_pkg.sv */
// shared types for the pipeline; an all-zero ctrl_t is a bubble
`include "cpu_defs.svh"

package cpu_pkg;

    typedef logic [`CPU_WORD_W-1:0]  word_t;
    typedef logic [`CPU_REG_AW-1:0]  reg_addr_t;
    typedef logic [`CPU_IMEM_AW-1:0] imem_addr_t;
    typedef logic [`CPU_DMEM_AW-1:0] dmem_addr_t;

    // ALU_ADD must stay zero so a bubble decodes as a harmless add
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4
    } alu_op_e;

    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    alu_src_imm;   // second operand is the immediate
        logic    mem_to_reg;    // writeback takes load data
        alu_op_e alu_op;
    } ctrl_t;

    typedef struct packed {
        ctrl_t     ctrl;
        word_t     rs_val;
        word_t     rt_val;
        word_t     imm;         // already sign extended
        reg_addr_t dest;
    } id_ex_t;

    typedef struct packed {
        ctrl_t     ctrl;
        word_t     alu_result;
        word_t     store_data;
        reg_addr_t dest;
    } ex_mem_t;

    typedef struct packed {
        logic      reg_write;
        reg_addr_t dest;
        word_t     data;
    } wb_t;

endpackage

/* logic/fetch_stage.sv */
// PC and instruction memory; the memory has no reset and is loaded through the write port
// PC saturates at the last word, so a program must end within the memory
`timescale 1ns/1ps
`include "cpu_defs.svh"

module fetch_stage (
    input  logic                SYS_clk,
    input  logic                SYS_reset,
    input  logic                stall,
    input  logic                load_en,
    input  cpu_pkg::imem_addr_t load_addr,
    input  cpu_pkg::word_t      load_data,
    output cpu_pkg::word_t      instr,
    output cpu_pkg::imem_addr_t pc
);
    import cpu_pkg::*;

    localparam imem_addr_t LAST_PC = imem_addr_t'(`CPU_IMEM_DEPTH - 1);

    word_t      imem [`CPU_IMEM_DEPTH];
    imem_addr_t pc_q;

    // load port, meant to be used while the core is held in reset
    always_ff @(posedge SYS_clk)
    begin
        if (load_en)
            imem[load_addr] <= load_data;
    end

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
            pc_q <= '0;
        else if (!stall && pc_q != LAST_PC)
            pc_q <= pc_q + 1'b1;    // one word per instruction
    end

    assign pc    = pc_q;
    assign instr = imem[pc_q];      // combinational read at PC

endmodule

/* logic/register_file.sv */
// 32 x 32 register file where r0 reads zero and ignores writes
// every read port sees a write landing on the same edge
`timescale 1ns/1ps
`include "cpu_defs.svh"

module register_file (
    input  logic               SYS_clk,
    input  logic               SYS_reset,
    input  cpu_pkg::reg_addr_t rs_addr,
    input  cpu_pkg::reg_addr_t rt_addr,
    input  cpu_pkg::reg_addr_t dbg_addr,
    input  cpu_pkg::wb_t       wb,
    output cpu_pkg::word_t     rs_data,
    output cpu_pkg::word_t     rt_data,
    output cpu_pkg::word_t     dbg_data
);
    import cpu_pkg::*;

    word_t regs [2**`CPU_REG_AW];

    function automatic word_t read_port(input reg_addr_t addr);
        if (addr == '0)
            return '0;
        else if (wb.reg_write && wb.dest == addr)
            return wb.data;     // bypass the pending write
        else
            return regs[addr];
    endfunction

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            for (int i = 0; i < 2**`CPU_REG_AW; i++)
                regs[i] <= '0;
        end
        else if (wb.reg_write && wb.dest != '0)
            regs[wb.dest] <= wb.data;
    end

    always_comb
    begin
        rs_data  = read_port(rs_addr);
        rt_data  = read_port(rt_addr);
        dbg_data = read_port(dbg_addr);
    end

endmodule

/* logic/decode_stage.sv */
// decode register, control decode and register interlock against execute and memory
// the last instruction word issues once; after that decode feeds bubbles
`timescale 1ns/1ps
`include "cpu_defs.svh"

module decode_stage (
    input  logic                SYS_clk,
    input  logic                SYS_reset,
    input  cpu_pkg::word_t      instr,
    input  cpu_pkg::imem_addr_t pc,
    input  cpu_pkg::reg_addr_t  ex_dest,
    input  logic                ex_reg_write,
    input  cpu_pkg::reg_addr_t  mem_dest,
    input  logic                mem_reg_write,
    input  cpu_pkg::wb_t        wb,
    input  cpu_pkg::reg_addr_t  dbg_addr,
    output cpu_pkg::word_t      dbg_data,
    output logic                stall,
    output cpu_pkg::id_ex_t     id_ex
);
    import cpu_pkg::*;

    localparam imem_addr_t LAST_PC = imem_addr_t'(`CPU_IMEM_DEPTH - 1);

    word_t     dec_instr;
    logic      last_issued;
    logic [5:0] opcode;
    logic [5:0] funct;
    reg_addr_t rs;
    reg_addr_t rt;
    word_t     rs_data;
    word_t     rt_data;
    ctrl_t     ctrl;
    logic      rt_read;
    logic      fn_valid;
    alu_op_e   fn_op;
    logic      rs_hazard;
    logic      rt_hazard;

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            dec_instr   <= '0;
            last_issued <= 1'b0;
        end
        else if (!stall)
        begin
            dec_instr <= last_issued ? '0 : instr;
            if (pc == LAST_PC)
                last_issued <= 1'b1;
        end
    end

    assign opcode = dec_instr[31:26];
    assign funct  = dec_instr[5:0];
    assign rs     = dec_instr[25:21];
    assign rt     = dec_instr[20:16];

    always_comb
    begin
        fn_valid = 1'b1;
        fn_op    = ALU_ADD;
        case (funct)
            `CPU_FN_ADD: fn_op = ALU_ADD;
            `CPU_FN_SUB: fn_op = ALU_SUB;
            `CPU_FN_AND: fn_op = ALU_AND;
            `CPU_FN_OR:  fn_op = ALU_OR;
            `CPU_FN_SLT: fn_op = ALU_SLT;
            default:     fn_valid = 1'b0;
        endcase
    end

    // unknown opcodes and function codes fall through as all-zero control
    always_comb
    begin
        ctrl    = '0;
        rt_read = 1'b0;
        case (opcode)
            `CPU_OP_RTYPE:
            begin
                ctrl.reg_write = fn_valid;
                ctrl.alu_op    = fn_op;
                rt_read        = fn_valid;
            end
            `CPU_OP_ADDI:
            begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
            end
            `CPU_OP_LW:
            begin
                ctrl.reg_write   = 1'b1;
                ctrl.mem_read    = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.mem_to_reg  = 1'b1;
            end
            `CPU_OP_SW:
            begin
                ctrl.mem_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                rt_read          = 1'b1;    // store data
            end
            default: ctrl = '0;
        endcase
    end

    // writeback needs no check since the register file forwards it
    assign rs_hazard = (rs != '0) && ((ex_reg_write && ex_dest == rs) ||
                                      (mem_reg_write && mem_dest == rs));
    assign rt_hazard = rt_read && (rt != '0) && ((ex_reg_write && ex_dest == rt) ||
                                                 (mem_reg_write && mem_dest == rt));
    assign stall     = rs_hazard || rt_hazard;

    always_comb
    begin
        id_ex.ctrl   = ctrl;
        id_ex.rs_val = rs_data;
        id_ex.rt_val = rt_data;
        id_ex.imm    = {{(`CPU_WORD_W - 16){dec_instr[15]}}, dec_instr[15:0]};
        id_ex.dest   = (opcode == `CPU_OP_RTYPE) ? dec_instr[15:11] : rt;   // rd or rt
    end

    register_file u_register_file (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .rs_addr   (rs),
        .rt_addr   (rt),
        .dbg_addr  (dbg_addr),
        .rs_data   (rs_data),
        .rt_data   (rt_data),
        .dbg_data  (dbg_data),
        .wb        (wb)
    );

    // an interlock clears after at most two stall cycles
    a_stall_bounded : assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        (stall && $past(stall)) |=> !stall);

endmodule

/* logic/execute_stage.sv */
// execute register and ALU; add and sub wrap, slt compares signed
// a stall loads a bubble, only the control bundle is cleared
`timescale 1ns/1ps

module execute_stage (
    input  logic                SYS_clk,
    input  logic                SYS_reset,
    input  logic                stall,
    input  cpu_pkg::id_ex_t     id_ex,
    output cpu_pkg::ex_mem_t    ex_fwd,
    output cpu_pkg::reg_addr_t  ex_dest,
    output logic                ex_reg_write
);
    import cpu_pkg::*;

    id_ex_t ex_q;
    word_t  op_b;
    word_t  alu_result;

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset || stall)
            ex_q.ctrl <= '0;            // bubble
        else
            ex_q <= id_ex;
    end

    assign op_b = ex_q.ctrl.alu_src_imm ? ex_q.imm : ex_q.rt_val;

    always_comb
    begin
        case (ex_q.ctrl.alu_op)
            ALU_ADD: alu_result = ex_q.rs_val + op_b;
            ALU_SUB: alu_result = ex_q.rs_val - op_b;
            ALU_AND: alu_result = ex_q.rs_val & op_b;
            ALU_OR:  alu_result = ex_q.rs_val | op_b;
            ALU_SLT:
            begin
                alu_result = '0;
                alu_result[0] = $signed(ex_q.rs_val) < $signed(op_b);
            end
            default: alu_result = '0;
        endcase
    end

    always_comb
    begin
        ex_fwd.ctrl       = ex_q.ctrl;
        ex_fwd.alu_result = alu_result;
        ex_fwd.store_data = ex_q.rt_val;    // sw data comes from rt
        ex_fwd.dest       = ex_q.dest;
    end

    assign ex_dest      = ex_q.dest;
    assign ex_reg_write = ex_q.ctrl.reg_write;

endmodule

/* logic/result_stage.sv */
// memory and writeback registers with a 16-word data memory
// word index is byte address bits 5:2, so addresses wrap every 16 words
`timescale 1ns/1ps
`include "cpu_defs.svh"

module result_stage (
    input  logic               SYS_clk,
    input  logic               SYS_reset,
    input  cpu_pkg::ex_mem_t   ex_fwd,
    output cpu_pkg::reg_addr_t mem_dest,
    output logic               mem_reg_write,
    output cpu_pkg::wb_t       wb
);
    import cpu_pkg::*;

    ex_mem_t    mem_q;
    dmem_addr_t dmem_idx;
    word_t      dmem [`CPU_DMEM_DEPTH];

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
            mem_q.ctrl <= '0;
        else
            mem_q <= ex_fwd;
    end

    assign dmem_idx = mem_q.alu_result[`CPU_DMEM_AW+1:2];

    // data words start at zero after reset
    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            for (int i = 0; i < `CPU_DMEM_DEPTH; i++)
                dmem[i] <= '0;
        end
        else if (mem_q.ctrl.mem_write)
            dmem[dmem_idx] <= mem_q.store_data;
    end

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
            wb.reg_write <= 1'b0;
        else
        begin
            wb.reg_write <= mem_q.ctrl.reg_write;
            wb.dest      <= mem_q.dest;
            wb.data      <= mem_q.ctrl.mem_to_reg ? dmem[dmem_idx] : mem_q.alu_result;
        end
    end

    assign mem_dest      = mem_q.dest;
    assign mem_reg_write = mem_q.ctrl.reg_write;

    a_rw_exclusive : assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        !(mem_q.ctrl.mem_read && mem_q.ctrl.mem_write));

endmodule

/* logic/cpu_top.sv */
// five-step in-order core, no branches, hazards resolved by a decode interlock
// load the instruction memory while SYS_reset is high
`timescale 1ns/1ps

module cpu_top (
    input  logic                SYS_clk,
    input  logic                SYS_reset,
    input  logic                load_en,
    input  cpu_pkg::imem_addr_t load_addr,
    input  cpu_pkg::word_t      load_data,
    input  cpu_pkg::reg_addr_t  dbg_addr,
    output cpu_pkg::word_t      dbg_data
);
    import cpu_pkg::*;

    word_t      instr;
    imem_addr_t pc;
    logic       stall;
    id_ex_t     id_ex;
    ex_mem_t    ex_fwd;
    reg_addr_t  ex_dest;
    logic       ex_reg_write;
    reg_addr_t  mem_dest;
    logic       mem_reg_write;
    wb_t        wb;

    fetch_stage u_fetch (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .stall     (stall),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .instr     (instr),
        .pc        (pc)
    );

    decode_stage u_decode (
        .SYS_clk       (SYS_clk),
        .SYS_reset     (SYS_reset),
        .instr         (instr),
        .pc            (pc),
        .ex_dest       (ex_dest),
        .ex_reg_write  (ex_reg_write),
        .mem_dest      (mem_dest),
        .mem_reg_write (mem_reg_write),
        .wb            (wb),
        .dbg_addr      (dbg_addr),
        .dbg_data      (dbg_data),
        .stall         (stall),
        .id_ex         (id_ex)
    );

    execute_stage u_execute (
        .SYS_clk      (SYS_clk),
        .SYS_reset    (SYS_reset),
        .stall        (stall),
        .id_ex        (id_ex),
        .ex_fwd       (ex_fwd),
        .ex_dest      (ex_dest),
        .ex_reg_write (ex_reg_write)
    );

    result_stage u_result (
        .SYS_clk       (SYS_clk),
        .SYS_reset     (SYS_reset),
        .ex_fwd        (ex_fwd),
        .mem_dest      (mem_dest),
        .mem_reg_write (mem_reg_write),
        .wb            (wb)
    );

endmodule

/* tb/cpu_tb.sv */
// programs are loaded while SYS_reset is high, then reset stays high 4 more cycles
// results are read back through the debug port after a fixed drain bound
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu_tb;
    import cpu_pkg::*;

    localparam int CLK_PERIOD   = 100;
    localparam int IMEM_WORDS   = `CPU_IMEM_DEPTH;
    localparam int WAIT_CYCLES  = 3 * IMEM_WORDS + 8;
    localparam int TEST_CYCLES  = IMEM_WORDS + 6 + WAIT_CYCLES + 32 + 4;
    localparam int NUM_TESTS    = 5 + 10;
    localparam int WATCHDOG_CYC = NUM_TESTS * TEST_CYCLES + 100;

    logic       SYS_clk;
    logic       SYS_reset;
    logic       load_en;
    imem_addr_t load_addr;
    word_t      load_data;
    reg_addr_t  dbg_addr;
    word_t      dbg_data;

    logic [31:0] prog [IMEM_WORDS];
    int          prog_len;
    logic [31:0] model_regs [32];
    logic [31:0] model_mem [`CPU_DMEM_DEPTH];
    logic [31:0] lfsr_state = 32'hb00b;

    cpu_top DUT (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .dbg_addr  (dbg_addr),
        .dbg_data  (dbg_data)
    );

    initial
    begin
        SYS_clk = 1'b0;
        forever #(CLK_PERIOD / 2) SYS_clk = ~SYS_clk;
    end

    // galois form, taps 32,22,2,1; one step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] value;
        logic        out_bit;
        value = '0;
        for (int i = 0; i < n; i++)
        begin
            out_bit    = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (out_bit)
                lfsr_state = lfsr_state ^ 32'h80200003;
            value = {value[30:0], out_bit};
        end
        return value;
    endfunction

    function automatic logic [31:0] r_instr(input logic [5:0] fn, input logic [4:0] rd,
                                            input logic [4:0] rs, input logic [4:0] rt);
        return {`CPU_OP_RTYPE, rs, rt, rd, 5'h00, fn};
    endfunction

    function automatic logic [31:0] i_instr(input logic [5:0] op, input logic [4:0] rt,
                                            input logic [4:0] rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // runs the program one instruction at a time, no pipeline
    function automatic void run_model();
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] addr;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        for (int i = 0; i < 32; i++)
            model_regs[i] = '0;
        for (int i = 0; i < `CPU_DMEM_DEPTH; i++)
            model_mem[i] = '0;
        for (int pc = 0; pc < IMEM_WORDS; pc++)
        begin
            ins  = prog[pc];
            rs   = ins[25:21];
            rt   = ins[20:16];
            rd   = ins[15:11];
            a    = model_regs[rs];
            b    = model_regs[rt];
            imm  = {{16{ins[15]}}, ins[15:0]};
            addr = a + imm;
            case (ins[31:26])
                `CPU_OP_RTYPE:
                begin
                    if (rd != 0)
                    begin
                        case (ins[5:0])
                            `CPU_FN_ADD: model_regs[rd] = a + b;
                            `CPU_FN_SUB: model_regs[rd] = a - b;
                            `CPU_FN_AND: model_regs[rd] = a & b;
                            `CPU_FN_OR:  model_regs[rd] = a | b;
                            `CPU_FN_SLT: model_regs[rd] = ($signed(a) < $signed(b)) ? 1 : 0;
                            default:     model_regs[rd] = model_regs[rd];   // unknown funct
                        endcase
                    end
                end
                `CPU_OP_ADDI: if (rt != 0) model_regs[rt] = addr;
                `CPU_OP_LW:   if (rt != 0) model_regs[rt] = model_mem[addr[5:2]];
                `CPU_OP_SW:   model_mem[addr[5:2]] = b;
                default:      model_regs[0] = '0;   // unknown opcode, no effect
            endcase
        end
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected)
        begin
            $display("Fail %s expected %h actual %h", name, expected, actual);
            $display("TEST FAIL");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic clear_program();
        for (int i = 0; i < IMEM_WORDS; i++)
            prog[i] = '0;
        prog_len = 0;
    endtask

    task automatic put(input logic [31:0] word);
        prog[prog_len] = word;
        prog_len++;
    endtask

    task automatic reset_and_load();
        @(posedge SYS_clk);
        SYS_reset <= 1'b1;
        for (int i = 0; i < IMEM_WORDS; i++)
        begin
            load_en   <= 1'b1;
            load_addr <= imem_addr_t'(i);
            load_data <= prog[i];
            @(posedge SYS_clk);
        end
        load_en <= 1'b0;
        repeat (4) @(posedge SYS_clk);
        SYS_reset <= 1'b0;
    endtask

    // compare process for one test, all 32 registers
    task automatic run_test(input string name);
        reset_and_load();
        run_model();
        repeat (WAIT_CYCLES) @(posedge SYS_clk);
        for (int r = 0; r < 32; r++)
        begin
            @(posedge SYS_clk);
            dbg_addr <= reg_addr_t'(r);
            @(negedge SYS_clk);    // debug read settled
            check_value($sformatf("%s r%0d", name, r), model_regs[r], dbg_data);
        end
    endtask

    task automatic build_random_program();
        logic [2:0]  kind;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [15:0] imm;
        clear_program();
        for (int i = 0; i < 20; i++)
        begin
            kind = 3'(take_bits(3));
            rs   = 5'(take_bits(3));    // registers 0..7 only
            rt   = 5'(take_bits(3));
            rd   = 5'(take_bits(3));
            imm  = 16'(take_bits(16));
            case (kind)
                3'd0: put(r_instr(`CPU_FN_ADD, rd, rs, rt));
                3'd1: put(r_instr(`CPU_FN_SUB, rd, rs, rt));
                3'd2: put(r_instr(`CPU_FN_AND, rd, rs, rt));
                3'd3: put(r_instr(`CPU_FN_OR, rd, rs, rt));
                3'd4: put(r_instr(`CPU_FN_SLT, rd, rs, rt));
                3'd5: put(i_instr(`CPU_OP_ADDI, rt, rs, imm));
                3'd6: put(i_instr(`CPU_OP_LW, rt, rs, imm));
                default: put(i_instr(`CPU_OP_SW, rt, rs, imm));
            endcase
        end
    endtask

    initial
    begin
        SYS_reset = 1'b1;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        dbg_addr  = '0;

        clear_program();
        run_test("reset");

        clear_program();
        put(i_instr(`CPU_OP_ADDI, 5'd1, 5'd0, 16'd100));
        put(i_instr(`CPU_OP_ADDI, 5'd2, 5'd0, 16'hfff9));     // -7
        put(r_instr(`CPU_FN_ADD, 5'd3, 5'd1, 5'd2));
        put(r_instr(`CPU_FN_SUB, 5'd4, 5'd2, 5'd1));         // negative result
        put(r_instr(`CPU_FN_AND, 5'd5, 5'd1, 5'd2));
        put(r_instr(`CPU_FN_OR, 5'd6, 5'd1, 5'd2));
        put(r_instr(`CPU_FN_SLT, 5'd7, 5'd2, 5'd1));         // signed, -7 < 100
        put(r_instr(`CPU_FN_SLT, 5'd8, 5'd1, 5'd2));
        put(i_instr(`CPU_OP_ADDI, 5'd9, 5'd2, 16'h8000));
        put(r_instr(`CPU_FN_SUB, 5'd10, 5'd0, 5'd1));
        put(r_instr(`CPU_FN_SLT, 5'd11, 5'd10, 5'd0));
        run_test("alu");

        clear_program();
        for (int i = 0; i < 20; i++)
            put(i_instr(`CPU_OP_ADDI, 5'd1, 5'd1, 16'd1));
        put(r_instr(`CPU_FN_ADD, 5'd2, 5'd1, 5'd1));
        run_test("chain");

        clear_program();
        put(i_instr(`CPU_OP_ADDI, 5'd1, 5'd0, 16'h1234));
        put(i_instr(`CPU_OP_ADDI, 5'd2, 5'd0, 16'hffff));
        put(i_instr(`CPU_OP_SW, 5'd1, 5'd0, 16'd0));
        put(i_instr(`CPU_OP_SW, 5'd2, 5'd0, 16'd4));
        put(i_instr(`CPU_OP_SW, 5'd2, 5'd0, 16'd60));
        put(i_instr(`CPU_OP_ADDI, 5'd3, 5'd0, 16'd5));
        put(i_instr(`CPU_OP_SW, 5'd3, 5'd0, 16'd68));        // word 17 wraps to 1
        put(i_instr(`CPU_OP_LW, 5'd4, 5'd0, 16'd0));
        put(i_instr(`CPU_OP_LW, 5'd5, 5'd0, 16'd4));
        put(r_instr(`CPU_FN_ADD, 5'd6, 5'd4, 5'd5));         // load-use
        put(i_instr(`CPU_OP_LW, 5'd7, 5'd0, 16'd60));
        put(i_instr(`CPU_OP_LW, 5'd8, 5'd1, 16'hedcc));      // base plus negative offset
        run_test("memory");

        clear_program();
        put(i_instr(`CPU_OP_ADDI, 5'd0, 5'd0, 16'd55));
        put(i_instr(`CPU_OP_ADDI, 5'd1, 5'd0, 16'd9));
        put(r_instr(`CPU_FN_ADD, 5'd0, 5'd1, 5'd1));
        put({6'h3f, 5'd1, 5'd2, 16'h0011});
        put(r_instr(6'h3f, 5'd5, 5'd1, 5'd1));
        put(i_instr(`CPU_OP_LW, 5'd0, 5'd0, 16'd0));
        put(r_instr(`CPU_FN_ADD, 5'd3, 5'd0, 5'd1));
        run_test("zero_reg");

        for (int t = 0; t < 10; t++)
        begin
            build_random_program();
            run_test($sformatf("random%0d", t));
        end

        $display("TEST PASS");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_CYC * CLK_PERIOD);
        $display("timeout: the tests did not finish within the expected time");
        $display("TEST FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule

/* sim.f */
+incdir+logic
logic/cpu_pkg.sv
logic/fetch_stage.sv
logic/register_file.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/result_stage.sv
logic/cpu_top.sv
tb/cpu_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = cpu_tb
FILELIST  = sim.f
OBJ_DIR   = obj_dir
BIN       = $(OBJ_DIR)/V$(TOP)
SRCS      = $(wildcard logic/*.sv logic/*.svh tb/*.sv)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	@out="$$(./$(BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)
